/* test/tb_zx_core.sv */
//==================================================
// Testbench for zx_core_top that stops at a cycle limit
// Random map checks run in +3 mode with 7FFD unlocked
//==================================================
`timescale 1ns/10ps

module tb_zx_core import zx_pkg::*; ();

	localparam logic [1:0] OP_WR  = 2'd0;
	localparam logic [1:0] OP_MEM = 2'd1;
	localparam logic [1:0] OP_RD  = 2'd2;
	localparam logic [1:0] OP_ULA = 2'd3;
	localparam int RAND_N = 24;

	typedef struct packed {
		logic        rst;
		logic [2:0]  mode;
		logic [1:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [11:0] exp;
		logic [5:0]  j0;
		logic [5:0]  j1;
		logic [1:0]  jsel;
		logic        ear;
	} row_t;

	logic                  clk_sys;
	logic                  reset;
	cpu_bus_t              cpu;
	logic [2:0]            mem_mode;
	logic [7:0]            ram_dout;
	joy_t                  joy0;
	joy_t                  joy1;
	logic [1:0]            joy_sel;
	logic [4:0]            key_data;
	logic                  ear_in;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_rd;
	logic                  ram_we;
	logic [7:0]            cpu_din;
	logic [2:0]            border;
	logic                  ear_out;
	logic                  mic_out;

	row_t stim_q[$];
	int   errors = 0;
	int   checks = 0;
	int   cycles = 0;
	int   limit  = 1000000;

	zx_core_top u_dut (.*);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout: tests still running after %0d cycles", limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// +3 map model with page_ext held at 0
	function automatic int model_bank(input logic [7:0] p1, input logic [7:0] p7,
		input logic [15:0] addr);
		int slot;
		slot = addr[15:14];
		if (p1[0]) begin
			case (p1[2:1])
				2'd0:    return slot;
				2'd1:    return slot + 4;
				2'd2:    return (slot == 3) ? 3 : slot + 4;
				default: return (slot == 3) ? 3 : ((slot == 1) ? 7 : slot + 4);
			endcase
		end
		case (slot)
			0:       return 88 + 2 * p1[2] + p7[4];
			1:       return 5;
			2:       return 2;
			default: return p7[2:0];
		endcase
	endfunction

	task automatic add_row(input logic rst, input logic [2:0] mode, input logic [1:0] op,
		input logic [15:0] addr, input logic [7:0] data, input logic [11:0] exp,
		input logic [5:0] j0, input logic [5:0] j1, input logic [1:0] jsel, input logic ear);
		stim_q.push_back({rst, mode, op, addr, data, exp, j0, j1, jsel, ear});
	endtask

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic apply_reset(input logic [2:0] mode);
		mem_mode = mode;
		cpu      = '0;
		reset    = 1'b1;
		repeat (4) tick();
		reset = 1'b0;
	endtask

	// Level for 2 cycles, then 1 idle cycle
	task automatic port_write(input logic [15:0] addr, input logic [7:0] data);
		cpu      = '0;
		cpu.addr = addr;
		cpu.dout = data;
		cpu.iorq = 1'b1;
		cpu.wr   = 1'b1;
		tick();
		tick();
		cpu = '0;
		tick();
	endtask

	task automatic mem_check(input logic [15:0] addr, input logic write, input int exp_bank,
		input logic exp_we);
		cpu      = '0;
		cpu.addr = addr;
		cpu.mreq = 1'b1;
		cpu.wr   = write;
		cpu.rd   = ~write;
		@(negedge clk_sys);
		checks = checks + (write ? 3 : 4);
		if (ram_addr[RAM_ADDR_W-1:BANK_OFS_W] !== 11'(exp_bank) ||
			ram_addr[BANK_OFS_W-1:0] !== addr[BANK_OFS_W-1:0]) begin
			errors++;
			$display("error at %0t: addr %h gives ram_addr %h, expected bank %0d",
				$time, addr, ram_addr, exp_bank);
		end
		if (ram_we !== exp_we) begin
			errors++;
			$display("error at %0t: addr %h ram_we %b, expected %b",
				$time, addr, ram_we, exp_we);
		end
		if (ram_rd !== ~write) begin
			errors++;
			$display("error at %0t: addr %h ram_rd %b, expected %b",
				$time, addr, ram_rd, ~write);
		end
		if (!write && cpu_din !== ram_dout) begin
			errors++;
			$display("error at %0t: memory read gives %h, expected %h", $time, cpu_din, ram_dout);
		end
		tick();
		cpu = '0;
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] exp);
		cpu      = '0;
		cpu.addr = addr;
		cpu.iorq = 1'b1;
		cpu.rd   = 1'b1;
		@(negedge clk_sys);
		checks++;
		if (cpu_din !== exp) begin
			errors++;
			$display("error at %0t: port %h reads %h, expected %h", $time, addr, cpu_din, exp);
		end
		tick();
		cpu = '0;
	endtask

	task automatic ula_check(input logic [4:0] exp);
		@(negedge clk_sys);
		checks++;
		if ({ear_out, mic_out, border} !== exp) begin
			errors++;
			$display("error at %0t: ear/mic/border %b, expected %b", $time,
				{ear_out, mic_out, border}, exp);
		end
		tick();
	endtask

	initial begin : main
		row_t        r;
		logic [31:0] rnd;
		logic [7:0]  p1;
		logic [7:0]  p7;
		logic [15:0] addr;
		logic        exp_we;
		clk_sys  = 1'b0;
		reset    = 1'b1;
		mem_mode = MODE_128K;
		cpu      = '0;
		ram_dout = 8'h00;
		joy0     = '0;
		joy1     = '0;
		joy_sel  = 2'd0;
		key_data = 5'h1F;
		ear_in   = 1'b0;

		// ==================================================
		// Stimulus table
		// ==================================================
		// MEM rows expect {we, bank}
		add_row(0, MODE_128K,  OP_MEM, 16'h0123, 8'h00, {1'b0, 11'd86}, 0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_MEM, 16'h4567, 8'h00, {1'b1, 11'd5},  0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_MEM, 16'h89AB, 8'h00, {1'b1, 11'd2},  0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_MEM, 16'hCDEF, 8'h00, {1'b1, 11'd0},  0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_WR,  16'h7FFD, 8'h13, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_MEM, 16'hC010, 8'h00, {1'b1, 11'd3},  0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_MEM, 16'h0010, 8'h00, {1'b0, 11'd87}, 0, 0, 0, 0);
		// Lock bit holds the page until reset
		add_row(0, MODE_128K,  OP_WR,  16'h7FFD, 8'h21, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_MEM, 16'hC000, 8'h00, {1'b1, 11'd1},  0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_WR,  16'h7FFD, 8'h04, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_MEM, 16'hC000, 8'h00, {1'b1, 11'd1},  0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_MEM, 16'h0000, 8'h00, {1'b0, 11'd86}, 0, 0, 0, 0);
		add_row(1, MODE_48K,   OP_MEM, 16'h0000, 8'h00, {1'b0, 11'd95}, 0, 0, 0, 0);
		add_row(0, MODE_48K,   OP_WR,  16'h7FFD, 8'h07, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_48K,   OP_MEM, 16'hFFFF, 8'h00, {1'b1, 11'd0},  0, 0, 0, 0);
		// Extended page 7 times 8 plus page 1
		add_row(1, MODE_P1024, OP_WR,  16'h7FFD, 8'hE1, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_P1024, OP_MEM, 16'hC000, 8'h00, {1'b1, 11'd57}, 0, 0, 0, 0);
		add_row(1, MODE_P1024, OP_WR,  16'hEFF7, 8'h04, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_P1024, OP_WR,  16'h7FFD, 8'hE1, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_P1024, OP_MEM, 16'hC000, 8'h00, {1'b1, 11'd1},  0, 0, 0, 0);
		// ULA port and reads with key_data in the data column
		add_row(1, MODE_128K,  OP_WR,  16'h00FE, 8'h1D, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_ULA, 16'h0000, 8'h00, 12'h01D,        0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_RD,  16'h00FE, 8'h1F, 12'h0FF,        0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_RD,  16'h00FE, 8'h17, 12'h0B7,        0, 0, 0, 1);
		add_row(0, MODE_128K,  OP_RD,  16'h001F, 8'h1F, 12'h019, 6'h11, 6'h08, 0, 0);
		add_row(0, MODE_128K,  OP_RD,  16'hEFFE, 8'h1F, 12'h0FC, 6'h18, 6'h00, 1, 0);
		add_row(0, MODE_128K,  OP_RD,  16'h00FD, 8'h1F, 12'h0FF,        0, 0, 0, 0);
		add_row(0, MODE_128K,  OP_RD,  16'h001F, 8'h1F, 12'h0FF, 6'h11, 6'h00, 1, 0);
		// +3 ROM page, then the four all-RAM maps
		add_row(1, MODE_PLUS3, OP_MEM, 16'h0000, 8'h00, {1'b0, 11'd88}, 0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_WR,  16'h1FFD, 8'h01, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_MEM, 16'h0000, 8'h00, {1'b1, 11'd0},  0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_MEM, 16'hC000, 8'h00, {1'b1, 11'd3},  0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_WR,  16'h1FFD, 8'h03, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_MEM, 16'h0000, 8'h00, {1'b1, 11'd4},  0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_MEM, 16'hC000, 8'h00, {1'b1, 11'd7},  0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_WR,  16'h1FFD, 8'h05, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_MEM, 16'h4000, 8'h00, {1'b1, 11'd5},  0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_MEM, 16'hC000, 8'h00, {1'b1, 11'd3},  0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_WR,  16'h1FFD, 8'h07, 12'h000,        0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_MEM, 16'h4000, 8'h00, {1'b1, 11'd7},  0, 0, 0, 0);
		add_row(0, MODE_PLUS3, OP_MEM, 16'h0000, 8'h00, {1'b1, 11'd4},  0, 0, 0, 0);

		// Reset and table cycles plus 7 per random pass and a margin
		limit = 4 + 50 + 7 * RAND_N;
		for (int i = 0; i < stim_q.size(); i++) begin
			r = stim_q[i];
			limit += (r.rst ? 4 : 0) + ((r.op == OP_WR) ? 3 : 1);
		end

		apply_reset(MODE_128K);
		for (int i = 0; i < stim_q.size(); i++) begin
			r = stim_q[i];
			if (r.rst) begin
				apply_reset(r.mode);
			end
			joy0     = r.j0;
			joy1     = r.j1;
			joy_sel  = r.jsel;
			ear_in   = r.ear;
			key_data = r.data[4:0];
			case (r.op)
				OP_WR:   port_write(r.addr, r.data);
				OP_MEM:  mem_check(r.addr, 1'b1, int'(r.exp[10:0]), r.exp[11]);
				OP_RD:   read_check(r.addr, r.exp[7:0]);
				default: ula_check(r.exp[4:0]);
			endcase
		end

		// ==================================================
		// Random +3 mapping with the lock bit clear
		// ==================================================
		rnd = 32'd36531;
		for (int n = 0; n < RAND_N; n++) begin
			rnd      = next_random(rnd);
			p7       = {3'b000, rnd[12:8]};
			p1       = {5'b00000, rnd[2:0]};
			ram_dout = rnd[23:16];
			port_write(16'h7FFD, p7);
			port_write(16'h1FFD, p1);
			rnd    = next_random(rnd);
			addr   = rnd[15:0];
			exp_we = rnd[16] && (addr[15:14] != 2'd0 || p1[0]);
			mem_check(addr, rnd[16], model_bank(p1, p7, addr), exp_we);
		end

		errors = errors + u_dut.u_checker.fail_count;
		$display("checks: %0d, assertion failures: %0d, errors: %0d",
			checks, u_dut.u_checker.fail_count, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* test/zx_core_checker.sv */
//==================================================
// Bus and paging assertions bound into zx_core_top
//==================================================
`timescale 1ns/10ps

module zx_core_checker import zx_pkg::*; (
	input logic       clk_sys,
	input logic       reset,
	input cpu_bus_t   cpu,
	input logic       ram_we,
	input logic [7:0] ram_dout,
	input logic [7:0] cpu_din,
	input logic       ear_out,
	input logic       mic_out,
	input paging_t    paging
);

	int fail_count = 0;

	a_we_is_mem_write: assert property (@(posedge clk_sys) ram_we |-> (cpu.mreq && cpu.wr))
		else begin
			fail_count++;
			$error("ram_we high without a memory write");
		end

	a_ula_cleared: assert property (@(posedge clk_sys) $past(reset) |-> (!ear_out && !mic_out))
		else begin
			fail_count++;
			$error("ear_out or mic_out set after reset");
		end

	// 48K has no paging at all
	a_48k_fixed: assert property (@(posedge clk_sys) disable iff (reset)
		paging.zx48 |=> $stable(paging))
		else begin
			fail_count++;
			$error("paging state changed in 48K mode");
		end

	a_mem_read_data: assert property (@(posedge clk_sys)
		(cpu.mreq && cpu.rd) |-> (cpu_din == ram_dout))
		else begin
			fail_count++;
			$error("cpu_din differs from ram_dout on a memory read");
		end

endmodule

bind zx_core_top zx_core_checker u_checker (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.cpu      (cpu),
	.ram_we   (ram_we),
	.ram_dout (ram_dout),
	.cpu_din  (cpu_din),
	.ear_out  (ear_out),
	.mic_out  (mic_out),
	.paging   (paging)
);

/* verilog.f */
verilog/zx_pkg.sv
verilog/port_decoder.sv
verilog/paging_regs.sv
verilog/memory_mapper.sv
verilog/ula_port.sv
verilog/io_read_mux.sv
verilog/zx_core_top.sv
test/zx_core_checker.sv
test/tb_zx_core.sv

/* verilog/io_read_mux.sv */
//==================================================
// CPU read data select with joystick mapping
// On 48K the EAR output loops back into the read
//==================================================
`timescale 1ns/10ps

module io_read_mux import zx_pkg::*; (
	input  cpu_bus_t   cpu,
	input  paging_t    paging,
	input  logic [7:0] ram_dout,
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  logic [1:0] joy_sel,
	input  logic [4:0] key_data,
	input  logic       ear_in,
	input  logic       ear_out,
	output logic [7:0] cpu_din
);

	logic       io_rd;
	logic       kempston_sel;
	logic       ear_level;
	logic [4:0] sinclair;
	logic [4:0] joy_kbd;

	assign io_rd        = cpu.iorq & cpu.rd & ~cpu.m1;
	assign kempston_sel = io_rd & (cpu.addr[7:0] == 8'h1F) & (joy_sel == 2'd0);

	// Sinclair I sits on keys 6..0 of half row EFFE
	assign sinclair = {joy0.left, joy0.right, joy0.down, joy0.up, joy0.fire};
	assign joy_kbd  = ((joy_sel == 2'd1) && !cpu.addr[12]) ? ~sinclair : 5'h1F;

	// Issue 3 board behaviour
	assign ear_level = ear_in | (paging.zx48 & ear_out);

	always_comb begin
		if (cpu.mreq) begin
			cpu_din = ram_dout;
		end else if (kempston_sel) begin
			cpu_din = {2'b00, joy0 | joy1};
		end else if (io_rd && !cpu.addr[0]) begin
			cpu_din = {1'b1, ~ear_level, 1'b1, key_data & joy_kbd};
		end else begin
			cpu_din = 8'hFF;
		end
	end

endmodule

/* verilog/memory_mapper.sv */
//==================================================
// CPU address to RAM address map
// ROM banks live from bank 80 upward in the RAM
//==================================================
`timescale 1ns/10ps

module memory_mapper import zx_pkg::*; (
	input  cpu_bus_t              cpu,
	input  paging_t               paging,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we
);

	localparam int BANK_W = RAM_ADDR_W - BANK_OFS_W;

	logic [1:0]        slot;
	logic              special;
	logic [3:0]        rom_page;
	logic [2:0]        special_bank;
	logic [BANK_W-1:0] bank;

	assign slot    = cpu.addr[15:14];
	assign special = paging.plus3 & paging.page_1ffd[0];

	always_comb begin
		if (paging.zx48) begin
			rom_page = 4'd15;
		end else if (paging.plus3) begin
			rom_page = 4'd8 + {2'b00, paging.page_1ffd[2], paging.page_7ffd.zx128.rom_sel};
		end else begin
			rom_page = 4'd6 + {3'b000, paging.page_7ffd.zx128.rom_sel};
		end
	end

	// +3 all-RAM configurations
	always_comb begin
		case (paging.page_1ffd[2:1])
			2'd0:    special_bank = {1'b0, slot};
			2'd1:    special_bank = {1'b1, slot};
			2'd2:    special_bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
			default: special_bank = (slot == 2'd3) ? 3'd3 :
				(slot == 2'd1) ? 3'd7 : {1'b1, slot};
		endcase
	end

	always_comb begin
		if (special) begin
			bank = BANK_W'(special_bank);
		end else begin
			case (slot)
				2'd0:    bank = BANK_W'(80) + BANK_W'(rom_page);
				2'd1:    bank = BANK_W'(5);
				2'd2:    bank = BANK_W'(2);
				default: bank = BANK_W'({paging.page_ext, paging.page_7ffd.zx128.ram_page});
			endcase
		end
	end

	assign ram_addr = {bank, cpu.addr[BANK_OFS_W-1:0]};
	assign ram_rd   = cpu.mreq & cpu.rd;
	// ROM slot is read only unless special mode puts RAM there
	assign ram_we   = cpu.mreq & cpu.wr & (special | (slot != 2'd0));

endmodule

/* verilog/paging_regs.sv */
//==================================================
// Paging registers 7FFD, 1FFD and EFF7
// Unknown mem_mode values act as 128K
//==================================================
`timescale 1ns/10ps

module paging_regs import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  mem_mode_e   mem_mode,
	input  io_strobes_t strobes,
	output paging_t     paging
);

	logic       zx48;
	logic       p1024;
	logic       plus3;
	port_7ffd_u page_7ffd;
	logic [7:0] page_1ffd;
	logic [7:0] page_eff7;
	logic [2:0] page_ext;
	logic       page_disable;
	port_7ffd_u wr_byte;

	// Incoming byte seen through the union
	assign wr_byte = strobes.data;

	// ==================================================
	// Mode latch and registers
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zx48      <= (mem_mode == MODE_48K);
			p1024     <= (mem_mode == MODE_P1024);
			plus3     <= (mem_mode == MODE_PLUS3);
			page_7ffd <= '0;
			page_1ffd <= '0;
			page_eff7 <= '0;
			page_ext  <= '0;
		end else begin
			if (strobes.wr_7ffd) begin
				page_7ffd <= wr_byte;
				// Extended page only while EFF7 bit 2 leaves 1024K enabled
				if (p1024 && !page_eff7[2]) begin
					page_ext <= {wr_byte.p1024.ext_hi, wr_byte.p1024.ext_lo};
				end
			end
			if (strobes.wr_1ffd) begin
				page_1ffd <= strobes.data;
			end
			if (strobes.wr_eff7) begin
				page_eff7 <= strobes.data;
			end
		end
	end

	// Lock bit; on Pentagon 1024 it only counts in 128K compat mode
	always_comb begin
		if (zx48) begin
			page_disable = 1'b1;
		end else if (p1024) begin
			page_disable = page_7ffd.zx128.lock & page_eff7[2];
		end else begin
			page_disable = page_7ffd.zx128.lock;
		end
	end

	always_comb begin
		paging.page_7ffd    = page_7ffd;
		paging.page_1ffd    = page_1ffd;
		paging.page_eff7    = page_eff7;
		paging.page_ext     = page_ext;
		paging.zx48         = zx48;
		paging.p1024        = p1024;
		paging.plus3        = plus3;
		paging.page_disable = page_disable;
	end

endmodule

/* verilog/port_decoder.sv */
//==================================================
// I/O write edge detect and port decode
// A write level held high gives a single strobe
//==================================================
`timescale 1ns/10ps

module port_decoder import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  cpu_bus_t    cpu,
	input  logic        mode_plus3,
	input  logic        mode_p1024,
	input  logic        page_disable,
	output io_strobes_t strobes
);

	logic        io_wr;
	logic        io_wr_q;
	logic        wr_edge;
	logic [15:0] a;

	assign a     = cpu.addr;
	assign io_wr = cpu.iorq & cpu.wr & ~cpu.m1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// Strobe in the cycle the level first appears
	assign wr_edge = io_wr & ~io_wr_q;

	// ==================================================
	// Partial address decode
	// ==================================================
	// 7FFD needs a14 high on +3 so it does not alias 1FFD
	assign strobes.wr_7ffd = wr_edge & ~a[15] & ~a[1] & (a[14] | ~mode_plus3) & ~page_disable;
	assign strobes.wr_1ffd = wr_edge & mode_plus3 & ~page_disable &
		~a[15] & ~a[14] & ~a[13] & a[12] & ~a[1];
	assign strobes.wr_eff7 = wr_edge & mode_p1024 &
		a[15] & a[14] & a[13] & ~a[12] & ~a[3];
	assign strobes.wr_ula  = wr_edge & ~a[0];
	assign strobes.data    = cpu.dout;

endmodule

/* verilog/ula_port.sv */
//==================================================
// ULA output latch for border, EAR and MIC
//==================================================
`timescale 1ns/10ps

module ula_port import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  io_strobes_t strobes,
	output logic [2:0]  border,
	output logic        ear_out,
	output logic        mic_out
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= 3'd0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (strobes.wr_ula) begin
			border  <= strobes.data[2:0];
			ear_out <= strobes.data[4];
			mic_out <= strobes.data[3];
		end
	end

endmodule

/* verilog/zx_core_top.sv */
//==================================================
// Memory and port core of a Spectrum-family machine
// mem_mode is sampled only while reset is high
//==================================================
`timescale 1ns/10ps

module zx_core_top import zx_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cpu_bus_t              cpu,
	input  logic [2:0]            mem_mode,
	input  logic [7:0]            ram_dout,
	input  joy_t                  joy0,
	input  joy_t                  joy1,
	input  logic [1:0]            joy_sel,
	input  logic [4:0]            key_data,
	input  logic                  ear_in,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we,
	output logic [7:0]            cpu_din,
	output logic [2:0]            border,
	output logic                  ear_out,
	output logic                  mic_out
);

	io_strobes_t strobes;
	paging_t     paging;

	port_decoder u_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu          (cpu),
		.mode_plus3   (paging.plus3),
		.mode_p1024   (paging.p1024),
		.page_disable (paging.page_disable),
		.strobes      (strobes)
	);

	paging_regs u_paging (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mem_mode (mem_mode_e'(mem_mode)),
		.strobes  (strobes),
		.paging   (paging)
	);

	memory_mapper u_mapper (
		.cpu      (cpu),
		.paging   (paging),
		.ram_addr (ram_addr),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we)
	);

	ula_port u_ula (
		.clk_sys (clk_sys),
		.reset   (reset),
		.strobes (strobes),
		.border  (border),
		.ear_out (ear_out),
		.mic_out (mic_out)
	);

	io_read_mux u_rd (
		.cpu      (cpu),
		.paging   (paging),
		.ram_dout (ram_dout),
		.joy0     (joy0),
		.joy1     (joy1),
		.joy_sel  (joy_sel),
		.key_data (key_data),
		.ear_in   (ear_in),
		.ear_out  (ear_out),
		.cpu_din  (cpu_din)
	);

endmodule

/* verilog/zx_pkg.sv */
//==================================================
// Shared types for the Spectrum memory and port core
// All bus levels are active high. Banks are 16 KB
//==================================================

package zx_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int RAM_ADDR_W = 25;
	localparam int BANK_OFS_W = 14;

	// Memory mode, latched at reset
	typedef enum logic [2:0] {
		MODE_128K  = 3'd0,
		MODE_P1024 = 3'd1,
		MODE_48K   = 3'd3,
		MODE_PLUS3 = 3'd4
	} mem_mode_e;

	// ==================================================
	// CPU bus
	// ==================================================
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// ==================================================
	// Port 7FFD, read two ways
	// ==================================================
	typedef struct packed {
		logic [1:0] rsv;
		logic       lock;
		logic       rom_sel;
		logic       screen;
		logic [2:0] ram_page;
	} port_7ffd_zx128_t;

	// Pentagon 1024 reuses bits 7..5 as the extended page
	typedef struct packed {
		logic [1:0] ext_lo;
		logic       ext_hi;
		logic [4:0] low;
	} port_7ffd_p1024_t;

	typedef union packed {
		port_7ffd_zx128_t zx128;
		port_7ffd_p1024_t p1024;
	} port_7ffd_u;

	// One-cycle write strobes with the byte written
	typedef struct packed {
		logic       wr_7ffd;
		logic       wr_1ffd;
		logic       wr_eff7;
		logic       wr_ula;
		logic [7:0] data;
	} io_strobes_t;

	typedef struct packed {
		port_7ffd_u page_7ffd;
		logic [7:0] page_1ffd;
		logic [7:0] page_eff7;
		logic [2:0] page_ext;
		logic       zx48;
		logic       p1024;
		logic       plus3;
		logic       page_disable;
	} paging_t;

	// Pad word, pressed is high
	typedef struct packed {
		logic fire2;
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

endpackage
